/* flist.f */
mem_pkg.sv
icache.sv
mem_arbiter.sv
byte_engine.sv
mem_front.sv
tb_ram_model.sv
tb_mem_front.sv

/* Makefile */
# Verilator build and run for the memory front end testbench
VERILATOR  ?= verilator
TOP        ?= tb_mem_front
RTL_TOP    ?= mem_front
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= mem_pkg.sv icache.sv mem_arbiter.sv byte_engine.sv mem_front.sv
TB_SRCS    ?= tb_ram_model.sv tb_mem_front.sv
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(RTL_SRCS) $(TB_SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_mem_front.sv */
// testbench for mem_front covering the fetch port, data port, io stall and rdy_in pause
// expected data comes from the ram preload rule and a shadow of every store
`timescale 1ns/1ps
`default_nettype none

module tb_mem_front
  import mem_pkg::*;
();

  localparam int LIMIT = 64; // cycles allowed per handshake
  localparam int BUDGET_TIE   = 60;
  localparam int BUDGET_HIT   = 50;
  localparam int BUDGET_CONF  = 100;
  localparam int BUDGET_STORE = 300;
  localparam int BUDGET_IO    = 60;
  localparam int BUDGET_PAUSE = 40;
  localparam int WATCHDOG_CYCLES = 2 * (2 + BUDGET_TIE + BUDGET_HIT + BUDGET_CONF +
                                        BUDGET_STORE + BUDGET_IO + BUDGET_PAUSE);

  logic                   clk_in;
  logic                   rst_in;
  logic                   rdy_in;
  logic                   io_buffer_full;
  logic [7:0]             mem_din;
  logic [7:0]             mem_dout;
  logic [ADDR_WIDTH-1:0]  mem_a;
  logic                   mem_wr;
  logic                   fetch_req;
  logic [ADDR_WIDTH-1:0]  fetch_addr;
  logic                   fetch_valid;
  logic [INST_WIDTH-1:0]  fetch_inst;
  logic                   data_req;
  logic                   data_wr;
  logic [COUNT_WIDTH-1:0] data_width;
  logic [ADDR_WIDTH-1:0]  data_addr;
  logic [31:0]            data_wdata;
  logic                   data_done;
  logic [31:0]            data_rdata;
  logic [31:0]            io_count;
  logic [ADDR_WIDTH-1:0]  io_last_addr;
  logic [7:0]             io_last_data;

  int          errors;
  int          checks;
  int          tests_run;
  int          test_base;  // error count when the current test began
  string       cur_test;
  logic [31:0] rng_state;
  logic [7:0]  shadow [logic [31:0]]; // bytes written by stores

  mem_front dut_i (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
    .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr),
    .io_buffer_full(io_buffer_full),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_valid(fetch_valid), .fetch_inst(fetch_inst),
    .data_req(data_req), .data_wr(data_wr), .data_width(data_width),
    .data_addr(data_addr), .data_wdata(data_wdata),
    .data_done(data_done), .data_rdata(data_rdata)
  );

  tb_ram_model ram_i (
    .clk_in(clk_in), .rst_in(rst_in), .addr(mem_a), .wdata(mem_dout), .wr(mem_wr),
    .rdata(mem_din), .io_count(io_count), .io_last_addr(io_last_addr),
    .io_last_data(io_last_data)
  );

  always #2 clk_in = ~clk_in;

  // rdy_in low at an edge leaves the bus untouched in the next cycle
  bus_held_in_pause: assert property (@(posedge clk_in) disable iff (rst_in)
      !$past(rdy_in) |-> (!mem_wr && mem_a == $past(mem_a)))
    else begin
      $display("bus moved while rdy_in was low in test %s", cur_test);
      errors++;
    end

  io_write_waits: assert property (@(posedge clk_in) disable iff (rst_in)
      (mem_wr && mem_a[RAM_ADDR_BITS-1 -: 2] == IO_SEL) |-> !$past(io_buffer_full))
    else begin
      $display("io write issued while io_buffer_full was high in test %s", cur_test);
      errors++;
    end

  fetch_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
      fetch_valid |=> !fetch_valid)
    else begin
      $display("fetch_valid stayed high for two cycles in test %s", cur_test);
      errors++;
    end

  done_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
      data_done |=> !data_done)
    else begin
      $display("data_done stayed high for two cycles in test %s", cur_test);
      errors++;
    end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [7:0] preload_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h2545_f491;
    h = h ^ (h >> 15);
    return h[7:0];
  endfunction

  function automatic logic [7:0] expected_byte(input logic [31:0] a);
    if (shadow.exists(a)) return shadow[a];
    return preload_byte(a);
  endfunction

  // little-endian with the upper bytes left zero
  function automatic logic [31:0] expected_word(input logic [31:0] a, input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) w[8*i +: 8] = expected_byte(a + i);
    return w;
  endfunction

  task automatic compare_value(input logic [31:0] exp, input logic [31:0] act);
    checks++;
    value_ok: assert (act === exp)
      else begin
        $display("ERR %s expected %h actual %h", cur_test, exp, act);
        errors++;
      end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_base = errors;
  endtask

  task automatic close_test();
    tests_run++;
    $display("test %-10s %s, %0d errors", cur_test,
             (errors == test_base) ? "ok" : "bad", errors - test_base);
  endtask

  // lat counts cycles from the request cycle to the fetch_valid cycle
  task automatic fetch_word(input logic [31:0] a, output logic [31:0] inst, output int lat);
    int n;
    n = 0;
    @(posedge clk_in);
    fetch_req  <= 1'b1;
    fetch_addr <= a;
    do begin
      @(posedge clk_in);
      n++;
    end while (!fetch_valid && n < LIMIT);
    fetch_req <= 1'b0;
    inst = fetch_inst;
    lat  = n - 1;
    fetch_seen: assert (fetch_valid)
      else begin
        $display("no fetch_valid within %0d cycles in test %s", LIMIT, cur_test);
        errors++;
      end
  endtask

  task automatic access_data(input logic wr, input int width, input logic [31:0] a,
                             input logic [31:0] wd, output logic [31:0] rd);
    int n;
    n = 0;
    @(posedge clk_in);
    data_req   <= 1'b1;
    data_wr    <= wr;
    data_width <= COUNT_WIDTH'(width);
    data_addr  <= a;
    data_wdata <= wd;
    do begin
      @(posedge clk_in);
      n++;
    end while (!data_done && n < LIMIT);
    data_req <= 1'b0;
    rd = data_rdata;
    done_seen: assert (data_done)
      else begin
        $display("no data_done within %0d cycles in test %s", LIMIT, cur_test);
        errors++;
      end
    if (wr) begin
      for (int i = 0; i < width; i++) shadow[a + i] = wd[8*i +: 8];
    end
  endtask

  // runs first while last-served is still data so the refill wins the tie
  task automatic tie_fetch_and_load();
    logic [31:0] inst;
    logic [31:0] rd;
    logic [31:0] first_a;
    int          lat;
    int          n;
    start_test("tie");
    n = 0;
    fork
      fetch_word(32'h0000_1234, inst, lat);
      begin
        @(posedge clk_in); // refill_req and data_req meet at the arbiter
        access_data(1'b0, 4, 32'h0000_4568, '0, rd);
      end
      begin
        while (mem_a == '0 && n < LIMIT) begin
          @(posedge clk_in);
          n++;
        end
        first_a = mem_a;
      end
    join
    compare_value(32'h0000_1230, first_a);
    compare_value(expected_word(32'h0000_1234, 4), inst);
    compare_value(expected_word(32'h0000_4568, 4), rd);
    close_test();
  endtask

  task automatic miss_then_hit();
    logic [31:0] inst;
    int          lat;
    start_test("miss_hit");
    fetch_word(32'h0000_2a40, inst, lat);
    compare_value(expected_word(32'h0000_2a40, 4), inst);
    fetch_word(32'h0000_2a44, inst, lat); // other word of the same block
    compare_value(expected_word(32'h0000_2a44, 4), inst);
    compare_value(32'd1, 32'(lat));
    close_test();
  endtask

  task automatic index_conflict();
    logic [31:0] inst;
    logic [31:0] a;
    int          lat;
    start_test("conflict");
    for (int i = 0; i < 4; i++) begin
      a = (i % 2 == 0) ? 32'h0000_0518 : 32'h0000_0d1c; // same index 0xa3 with other tags
      fetch_word(a, inst, lat);
      compare_value(expected_word(a, 4), inst);
    end
    close_test();
  endtask

  task automatic store_load_widths();
    logic [31:0] addrs [9];
    int          widths [9];
    logic [31:0] rd;
    logic [31:0] a;
    start_test("store_load");
    for (int i = 0; i < 9; i++) begin
      widths[i] = 1 << (i % 3);
      addrs[i]  = next_random() & 32'h0001_ffff & ~32'(widths[i] - 1);
      access_data(1'b1, widths[i], addrs[i], next_random(), rd);
    end
    for (int i = 0; i < 9; i++) begin
      access_data(1'b0, widths[i], addrs[i], '0, rd);
      compare_value(expected_word(addrs[i], widths[i]), rd);
    end
    for (int i = 0; i < 3; i++) begin
      do begin
        a = next_random() & 32'h0001_fffc;
      end while (shadow.exists(a) || shadow.exists(a + 32'd1) ||
                 shadow.exists(a + 32'd2) || shadow.exists(a + 32'd3));
      access_data(1'b0, 1 << i, a, '0, rd);
      compare_value(expected_word(a, 1 << i), rd); // plain preload bytes
    end
    close_test();
  endtask

  task automatic io_write_stall();
    logic [31:0] rd;
    start_test("io_stall");
    @(posedge clk_in);
    io_buffer_full <= 1'b1;
    fork
      access_data(1'b1, 1, 32'h0003_0000, 32'h0000_00a5, rd);
      begin
        repeat (20) @(posedge clk_in);
        compare_value(32'd0, io_count);
        io_buffer_full <= 1'b0;
      end
    join
    compare_value(32'd1, io_count);
    compare_value(32'h0003_0000, io_last_addr);
    compare_value(32'h0000_00a5, {24'h0, io_last_data});
    close_test();
  endtask

  task automatic rdy_pause();
    logic [31:0] rd;
    start_test("pause");
    fork
      access_data(1'b0, 4, 32'h0000_7a3c, '0, rd);
      begin
        repeat (4) @(posedge clk_in); // two bytes out before the pause
        rdy_in <= 1'b0;
        repeat (6) @(posedge clk_in);
        rdy_in <= 1'b1;
      end
    join
    compare_value(expected_word(32'h0000_7a3c, 4), rd);
    close_test();
  endtask

  initial begin
    clk_in         = 1'b0;
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    fetch_req      = 1'b0;
    fetch_addr     = '0;
    data_req       = 1'b0;
    data_wr        = 1'b0;
    data_width     = '0;
    data_addr      = '0;
    data_wdata     = '0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    rng_state      = 32'd36;
    repeat (2) @(posedge clk_in);
    rst_in <= 1'b0;
    tie_fetch_and_load();
    miss_then_hit();
    index_conflict();
    store_load_widths();
    io_write_stall();
    rdy_pause();
    repeat (2) @(posedge clk_in);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_ram_model.sv */
// behavioral 128 KB ram plus io window for the memory front end testbench
// reads return a byte one cycle after the address, io writes go to a small log
`timescale 1ns/1ps
`default_nettype none

module tb_ram_model
  import mem_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [7:0]            wdata,
  input  logic                  wr,
  output logic [7:0]            rdata,
  output logic [31:0]           io_count,     // io writes since reset
  output logic [ADDR_WIDTH-1:0] io_last_addr,
  output logic [7:0]            io_last_data
);

  localparam int RAM_BYTES = 1 << (RAM_ADDR_BITS - 1);

  logic [7:0] ram [RAM_BYTES];
  logic       io_hit;

  // byte mixing rule, the testbench uses the same one
  function automatic logic [7:0] preload_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h2545_f491;
    h = h ^ (h >> 15);
    return h[7:0];
  endfunction

  initial begin
    for (int i = 0; i < RAM_BYTES; i++) ram[i] = preload_byte(i);
  end

  assign io_hit = (addr[RAM_ADDR_BITS-1 -: 2] == IO_SEL);

  always @(posedge clk_in) begin
    rdata <= io_hit ? 8'h00 : ram[addr[RAM_ADDR_BITS-2:0]]; // io reads as zero
    if (wr && !io_hit) ram[addr[RAM_ADDR_BITS-2:0]] <= wdata;
  end

  always @(posedge clk_in) begin
    if (rst_in) begin
      io_count <= '0;
    end else if (wr && io_hit) begin
      io_count     <= io_count + 32'd1;
      io_last_addr <= addr;
      io_last_data <= wdata;
    end
  end

endmodule

`default_nettype wire

/* mem_front.sv */
// memory front end top: instruction cache and data port sharing one byte-wide ram bus
// connect mem_* to the ram and io block, drive fetch_* and data_* as held requests
`timescale 1ns/1ps
`default_nettype none

module mem_front
  import mem_pkg::*;
(
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   rdy_in,    // low pauses bus issue

  input  logic [7:0]             mem_din,
  output logic [7:0]             mem_dout,
  output logic [ADDR_WIDTH-1:0]  mem_a,     // only 17:0 decoded
  output logic                   mem_wr,
  input  logic                   io_buffer_full,

  input  logic                   fetch_req,
  input  logic [ADDR_WIDTH-1:0]  fetch_addr,
  output logic                   fetch_valid,
  output logic [INST_WIDTH-1:0]  fetch_inst,

  input  logic                   data_req,
  input  logic                   data_wr,   // 1 for store
  input  logic [COUNT_WIDTH-1:0] data_width, // bytes, 1 2 or 4
  input  logic [ADDR_WIDTH-1:0]  data_addr,
  input  logic [31:0]            data_wdata,
  output logic                   data_done,
  output logic [31:0]            data_rdata
);

  // icache to arbiter
  logic                        refill_req;
  logic [ADDR_WIDTH-1:0]       refill_addr;
  logic                        refill_done;
  logic [BLOCK_DATA_WIDTH-1:0] refill_data;

  // arbiter to engine
  logic                        eng_start;
  mem_op_t                     eng_op;
  logic [ADDR_WIDTH-1:0]       eng_addr;
  logic [COUNT_WIDTH-1:0]      eng_count;
  logic [BLOCK_DATA_WIDTH-1:0] eng_wdata;
  logic                        eng_busy;
  logic                        eng_done;
  logic [BLOCK_DATA_WIDTH-1:0] eng_rdata;

  icache icache_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .refill_done (refill_done),
    .refill_data (refill_data)
  );

  mem_arbiter arbiter_i (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .refill_done (refill_done),
    .refill_data (refill_data),
    .data_req    (data_req),
    .data_wr     (data_wr),
    .data_width  (data_width),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_done   (data_done),
    .data_rdata  (data_rdata),
    .start       (eng_start),
    .op          (eng_op),
    .addr        (eng_addr),
    .count       (eng_count),
    .wdata       (eng_wdata),
    .busy        (eng_busy),
    .done        (eng_done),
    .rdata       (eng_rdata)
  );

  byte_engine engine_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .io_buffer_full (io_buffer_full),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .start          (eng_start),
    .op             (eng_op),
    .addr           (eng_addr),
    .count          (eng_count),
    .wdata          (eng_wdata),
    .busy           (eng_busy),
    .done           (eng_done),
    .rdata          (eng_rdata)
  );

endmodule

`default_nettype wire

/* byte_engine.sv */
// moves 1 to 8 bytes over the 8-bit ram bus, little-endian, one byte per issue cycle
// reads capture mem_din a cycle after their address; io writes wait on io_buffer_full
// rdy_in low pauses issue only, bytes already in flight are still captured
`timescale 1ns/1ps
`default_nettype none

module byte_engine
  import mem_pkg::*;
(
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        rdy_in,
  input  logic                        io_buffer_full,

  input  logic [7:0]                  mem_din,
  output logic [7:0]                  mem_dout,
  output logic [ADDR_WIDTH-1:0]       mem_a,
  output logic                        mem_wr,

  input  logic                        start,
  input  mem_op_t                     op,
  input  logic [ADDR_WIDTH-1:0]       addr,
  input  logic [COUNT_WIDTH-1:0]      count,
  input  logic [BLOCK_DATA_WIDTH-1:0] wdata,
  output logic                        busy,
  output logic                        done,
  output logic [BLOCK_DATA_WIDTH-1:0] rdata
);

  mem_op_t                     op_q;
  logic [ADDR_WIDTH-1:0]       addr_q;   // next byte address
  logic [COUNT_WIDTH-1:0]      count_q;
  logic [COUNT_WIDTH-1:0]      issue_cnt;
  logic [COUNT_WIDTH-1:0]      cap_cnt;
  logic [BLOCK_DATA_WIDTH-1:0] wdata_q;  // shifts out low byte first
  logic                        rd_issued; // mem_a carries a read address this cycle
  logic                        rd_valid;  // mem_din holds a requested byte this cycle
  logic                        io_stall;
  logic                        issue_ok;
  logic                        accept;

  assign accept = !busy && start;

  // io writes hold off while the uart buffer is full
  assign io_stall = (op_q == OP_WRITE) && (addr_q[RAM_ADDR_BITS-1 -: 2] == IO_SEL) &&
                    io_buffer_full;

  assign issue_ok = busy && !done && (issue_cnt != count_q) && rdy_in && !io_stall;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      mem_wr    <= 1'b0;
      mem_a     <= '0;
      rd_issued <= 1'b0;
      rd_valid  <= 1'b0;
      issue_cnt <= '0;
      cap_cnt   <= '0;
    end else begin
      done     <= 1'b0;
      rd_valid <= rd_issued;
      if (!busy) begin
        mem_wr    <= 1'b0;
        rd_issued <= 1'b0;
        if (start) begin
          busy      <= 1'b1;
          issue_cnt <= '0;
          cap_cnt   <= '0;
        end
      end else if (done) begin
        busy      <= 1'b0; // kept high through the done cycle
        mem_wr    <= 1'b0;
        rd_issued <= 1'b0;
      end else begin
        if (issue_ok) begin
          mem_a     <= addr_q;
          issue_cnt <= issue_cnt + COUNT_WIDTH'(1);
          mem_wr    <= (op_q == OP_WRITE);
          rd_issued <= (op_q == OP_READ);
        end else begin
          mem_wr    <= 1'b0; // mem_a keeps its last value
          rd_issued <= 1'b0;
        end

        if (rd_valid) begin
          cap_cnt <= cap_cnt + COUNT_WIDTH'(1);
          if (cap_cnt == count_q - COUNT_WIDTH'(1)) done <= 1'b1;
        end

        // last write byte was on the bus this cycle
        if (mem_wr && (issue_cnt == count_q)) done <= 1'b1;
      end
    end
  end

  // transfer parameters and data path
  always_ff @(posedge clk_in) begin
    if (accept) begin
      op_q    <= op;
      addr_q  <= addr;
      count_q <= count;
      wdata_q <= wdata;
      rdata   <= '0; // short reads come back zero-extended
    end else begin
      if (issue_ok) begin
        addr_q <= addr_q + ADDR_WIDTH'(1);
        if (op_q == OP_WRITE) begin
          mem_dout <= wdata_q[7:0];
          wdata_q  <= wdata_q >> 8;
        end
      end
      if (busy && rd_valid) begin
        rdata[8*cap_cnt +: 8] <= mem_din;
      end
    end
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
// shares the byte engine between icache refills and the data port
// ties go to the requester not served last, done is routed back to the owner
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import mem_pkg::*;
(
  input  logic                        clk_in,
  input  logic                        rst_in,

  input  logic                        refill_req,
  input  logic [ADDR_WIDTH-1:0]       refill_addr,
  output logic                        refill_done,
  output logic [BLOCK_DATA_WIDTH-1:0] refill_data,

  input  logic                        data_req,
  input  logic                        data_wr,
  input  logic [COUNT_WIDTH-1:0]      data_width,
  input  logic [ADDR_WIDTH-1:0]       data_addr,
  input  logic [31:0]                 data_wdata,
  output logic                        data_done,
  output logic [31:0]                 data_rdata,

  output logic                        start,
  output mem_op_t                     op,
  output logic [ADDR_WIDTH-1:0]       addr,
  output logic [COUNT_WIDTH-1:0]      count,
  output logic [BLOCK_DATA_WIDTH-1:0] wdata,
  input  logic                        busy,
  input  logic                        done,
  input  logic [BLOCK_DATA_WIDTH-1:0] rdata
);

  req_src_t    last_src; // updated when a transfer completes
  req_src_t    owner;    // requester of the transfer in flight
  req_src_t    pick;
  logic [31:0] width_mask;

  // last-served rule
  always_comb begin
    if (data_req && (!refill_req || last_src == SRC_ICACHE)) begin
      pick = SRC_DATA;
    end else begin
      pick = SRC_ICACHE;
    end
  end

  assign start = !busy && (refill_req || data_req);

  always_comb begin
    if (pick == SRC_DATA) begin
      op    = data_wr ? OP_WRITE : OP_READ;
      addr  = data_addr;
      count = data_width;
      wdata = BLOCK_DATA_WIDTH'(data_wdata);
    end else begin
      op    = OP_READ; // refill is always a whole block read
      addr  = refill_addr;
      count = COUNT_WIDTH'(BLOCK_BYTES);
      wdata = '0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      last_src <= SRC_DATA; // icache wins the first tie
      owner    <= SRC_DATA;
    end else begin
      if (start) owner <= pick;
      if (done)  last_src <= owner;
    end
  end

  always_comb begin
    case (data_width)
      COUNT_WIDTH'(1): width_mask = 32'h0000_00ff;
      COUNT_WIDTH'(2): width_mask = 32'h0000_ffff;
      default:         width_mask = 32'hffff_ffff;
    endcase
  end

  assign refill_done = done && (owner == SRC_ICACHE);
  assign refill_data = rdata;
  assign data_done   = done && (owner == SRC_DATA);
  assign data_rdata  = rdata[31:0] & width_mask; // zero-extended load
endmodule

`default_nettype wire

/* icache.sv */
// direct-mapped instruction cache, 256 blocks of two instructions
// answers a held fetch request with a one-cycle fetch_valid, refills over the arbiter
`timescale 1ns/1ps
`default_nettype none

module icache
  import mem_pkg::*;
(
  input  logic                        clk_in,
  input  logic                        rst_in,

  input  logic                        fetch_req,
  input  logic [ADDR_WIDTH-1:0]       fetch_addr,
  output logic                        fetch_valid,
  output logic [INST_WIDTH-1:0]       fetch_inst,

  output logic                        refill_req,
  output logic [ADDR_WIDTH-1:0]       refill_addr,
  input  logic                        refill_done,
  input  logic [BLOCK_DATA_WIDTH-1:0] refill_data
);

  logic [BLOCK_DATA_WIDTH-1:0] line_mem [BLOCK_NUM];
  logic [TAG_BITS-1:0]         tag_mem  [BLOCK_NUM];
  logic [BLOCK_NUM-1:0]        valid_q;

  logic [CACHE_WIDTH-1:0]      index;
  logic [TAG_BITS-1:0]         tag;
  logic [BLOCK_WIDTH-1:0]      word_sel;
  logic [BLOCK_DATA_WIDTH-1:0] line;
  logic                        hit;
  logic                        lookup;
  logic                        fill;

  // address split: tag 17:11, index 10:3, word 2
  assign index    = fetch_addr[CACHE_WIDTH+BLOCK_WIDTH+1 : BLOCK_WIDTH+2];
  assign tag      = fetch_addr[RAM_ADDR_BITS-1 -: TAG_BITS];
  assign word_sel = fetch_addr[BLOCK_WIDTH+1 : 2];

  assign line = line_mem[index];
  assign hit  = valid_q[index] && (tag_mem[index] == tag);

  // no new lookup while answering or refilling
  assign lookup = fetch_req && !fetch_valid && !refill_req;
  assign fill   = refill_req && refill_done;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      fetch_valid <= 1'b0;
      refill_req  <= 1'b0;
      valid_q     <= '0;
    end else begin
      fetch_valid <= 1'b0; // single cycle pulse
      if (fill) begin
        refill_req     <= 1'b0;
        valid_q[index] <= 1'b1;
        fetch_valid    <= 1'b1; // answer straight from the refill data
      end else if (lookup) begin
        if (hit) begin
          fetch_valid <= 1'b1;
        end else begin
          refill_req <= 1'b1; // held until refill_done
        end
      end
    end
  end

  // line storage and returned word
  always_ff @(posedge clk_in) begin
    if (fill) begin
      line_mem[index] <= refill_data;
      tag_mem[index]  <= tag;
      fetch_inst      <= refill_data[word_sel*INST_WIDTH +: INST_WIDTH];
    end else if (lookup && hit) begin
      fetch_inst <= line[word_sel*INST_WIDTH +: INST_WIDTH];
    end
    if (lookup && !hit) begin
      refill_addr <= {fetch_addr[ADDR_WIDTH-1:BLOCK_WIDTH+2], {(BLOCK_WIDTH+2){1'b0}}};
    end
  end

endmodule

`default_nettype wire

/* mem_pkg.sv */
// shared address map, cache geometry and bus encodings for the memory front end
// imported by every rtl file and by the testbench for the address map
`default_nettype none

package mem_pkg;

  localparam int ADDR_WIDTH    = 32;
  localparam int RAM_ADDR_BITS = 18; // 128 KB ram plus the io window at 17:16

  // cache geometry
  localparam int BLOCK_WIDTH = 1; // 2 instructions per block
  localparam int BLOCK_BYTES = 4 << BLOCK_WIDTH;
  localparam int CACHE_WIDTH = 8;
  localparam int BLOCK_NUM   = 1 << CACHE_WIDTH;
  localparam int TAG_BITS    = RAM_ADDR_BITS - CACHE_WIDTH - BLOCK_WIDTH - 2; // bits 17:11

  localparam int INST_WIDTH       = 32;
  localparam int BLOCK_DATA_WIDTH = 8 * BLOCK_BYTES; // widest engine transfer

  // mem_a[17:16] == 2'b11 selects io
  localparam logic [1:0] IO_SEL = 2'd3;

  // byte count of a transfer, 1 to 8
  localparam int COUNT_WIDTH = 4;

  // who owns the bus transfer
  typedef enum logic {
    SRC_ICACHE = 1'b0,
    SRC_DATA   = 1'b1
  } req_src_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_t;

endpackage

`default_nettype wire
